// ==== design/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

  // data path widths
  localparam int word_w     = 32;
  localparam int addr_w     = 32;
  localparam int reg_addr_w = 5;

  typedef logic [word_w-1:0]     word_t;
  typedef logic [addr_w-1:0]     addr_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // byte step between sequential instructions
  localparam addr_t instr_len = addr_t'(4);

  // decoded operation classes
  typedef enum logic [2:0] {
    op_alu    = 3'd0,
    op_load   = 3'd1,
    op_store  = 3'd2,
    op_branch = 3'd3,
    op_jal    = 3'd4,
    op_jalr   = 3'd5
  } op_t;

  // fetch -> decode -> predict sequencing
  typedef enum logic [1:0] {
    fetch_idle         = 2'd0,
    fetch_wait_instr   = 2'd1,
    fetch_wait_decode  = 2'd2,
    fetch_wait_predict = 2'd3
  } fetch_state_t;

  // retire side; a store blocks the head until memory answers
  typedef enum logic {
    commit_idle       = 1'b0,
    commit_store_wait = 1'b1
  } commit_state_t;

endpackage

`default_nettype wire

// ==== design/fetch_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer #(
  parameter int iq_depth = 8
) (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 can_alloc,
  input  wire                 flush,
  input  wire                 if_valid,
  input  wire rob_pkg::word_t if_instr,
  input  wire rob_pkg::addr_t if_pc,
  input  wire                 dc_valid,
  input  wire rob_pkg::op_t   dc_op,
  input  wire rob_pkg::reg_addr_t dc_rd,
  input  wire [2:0]           dc_func3,
  input  wire rob_pkg::word_t dc_imm,
  input  wire                 pd_valid,
  input  wire                 pd_taken,
  output logic                fetch_req,
  output logic                decode_req,
  output rob_pkg::word_t      dec_instr,
  output logic                pd_req,
  output logic                pc_write,
  output rob_pkg::addr_t      pc_value,
  output logic                alloc,
  output rob_pkg::op_t        alloc_op,
  output rob_pkg::reg_addr_t  alloc_rd,
  output logic [2:0]          alloc_func3,
  output rob_pkg::word_t      alloc_imm,
  output rob_pkg::addr_t      alloc_pc,
  output logic                alloc_pred
);
  import rob_pkg::*;

  fetch_state_t state;

  logic take_instr;
  logic take_decode;
  logic take_predict;

  // one allocation can still be in flight when can_alloc is sampled
  if (iq_depth < 4 || (iq_depth & (iq_depth - 1)) != 0) begin : g_depth_check
    $error("iq_depth must be a power of two and at least 4");
  end

  // responses count only in the matching state and outside a flush
  assign take_instr   = (state == fetch_wait_instr) && if_valid && !flush;
  assign take_decode  = (state == fetch_wait_decode) && dc_valid && !flush;
  assign take_predict = (state == fetch_wait_predict) && pd_valid && !flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= fetch_idle;
      fetch_req  <= 1'b0;
      decode_req <= 1'b0;
      pd_req     <= 1'b0;
      pc_write   <= 1'b0;
      alloc      <= 1'b0;
    end else begin
      fetch_req  <= 1'b0;
      decode_req <= 1'b0;
      pd_req     <= 1'b0;
      pc_write   <= 1'b0;
      alloc      <= 1'b0;
      if (flush) begin
        // drop whatever was outstanding
        state <= fetch_idle;
      end else begin
        case (state)
          fetch_idle: begin
            if (can_alloc) begin
              fetch_req <= 1'b1;
              state     <= fetch_wait_instr;
            end
          end
          fetch_wait_instr: begin
            if (take_instr) begin
              decode_req <= 1'b1;
              state      <= fetch_wait_decode;
            end
          end
          fetch_wait_decode: begin
            if (take_decode && dc_op == op_branch) begin
              pd_req <= 1'b1;
              state  <= fetch_wait_predict;
            end else if (take_decode) begin
              alloc    <= 1'b1;
              pc_write <= 1'b1;
              state    <= fetch_idle;
            end
          end
          default: begin
            if (take_predict) begin
              alloc    <= 1'b1;
              pc_write <= 1'b1;
              state    <= fetch_idle;
            end
          end
        endcase
      end
    end
  end

  // decoding pc and decoded fields, held until allocation
  always_ff @(posedge clk) begin
    if (take_instr) begin
      dec_instr <= if_instr;
      alloc_pc  <= if_pc;
    end
    if (take_decode) begin
      alloc_op    <= dc_op;
      alloc_rd    <= dc_rd;
      alloc_func3 <= dc_func3;
      alloc_imm   <= dc_imm;
      alloc_pred  <= 1'b0;
      pc_value    <= (dc_op == op_jal) ? alloc_pc + dc_imm : alloc_pc + instr_len;
    end
    if (take_predict) begin
      alloc_pred <= pd_taken;
      pc_value   <= pd_taken ? alloc_pc + alloc_imm : alloc_pc + instr_len;
    end
  end

endmodule

`default_nettype wire

// ==== design/rob_entries.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_entries #(
  parameter  int iq_depth = 8,
  localparam int tag_w    = $clog2(iq_depth)
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     alloc,
  input  wire rob_pkg::op_t       alloc_op,
  input  wire rob_pkg::reg_addr_t alloc_rd,
  input  wire [2:0]               alloc_func3,
  input  wire rob_pkg::word_t     alloc_imm,
  input  wire rob_pkg::addr_t     alloc_pc,
  input  wire                     alloc_pred,
  input  wire                     wb_valid,
  input  wire [tag_w-1:0]         wb_tag,
  input  wire rob_pkg::word_t     wb_result,
  input  wire rob_pkg::addr_t     wb_tar_addr,
  input  wire                     retire,
  input  wire                     flush,
  output logic                    can_alloc,
  output logic                    head_ready,
  output logic [tag_w-1:0]        head_tag,
  output rob_pkg::op_t            head_op,
  output rob_pkg::reg_addr_t      head_rd,
  output logic [2:0]              head_func3,
  output rob_pkg::word_t          head_imm,
  output rob_pkg::addr_t          head_pc,
  output logic                    head_pred,
  output rob_pkg::word_t          head_result,
  output rob_pkg::addr_t          head_tar_addr
);
  import rob_pkg::*;

  logic [tag_w-1:0] head;
  logic [tag_w-1:0] tail;
  logic [tag_w-1:0] used;

  // per-entry storage, indexed by tag
  logic      ent_ready    [iq_depth];
  op_t       ent_op       [iq_depth];
  reg_addr_t ent_rd       [iq_depth];
  logic [2:0] ent_func3   [iq_depth];
  word_t     ent_imm      [iq_depth];
  addr_t     ent_pc       [iq_depth];
  logic      ent_pred     [iq_depth];
  word_t     ent_result   [iq_depth];
  addr_t     ent_tar_addr [iq_depth];

  // head == tail is empty, so at most iq_depth-1 entries are live
  assign used = tail - head;

  // keep two of the usable slots free
  assign can_alloc  = used < tag_w'(iq_depth - 2);
  assign head_ready = (head != tail) && ent_ready[head];

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
    end else if (flush) begin
      // tags restart at 0
      head <= '0;
      tail <= '0;
    end else begin
      if (alloc) begin
        tail <= tail + 1'b1;
      end
      if (retire) begin
        head <= head + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wb_valid) begin
      ent_ready[wb_tag]    <= 1'b1;
      ent_result[wb_tag]   <= wb_result;
      ent_tar_addr[wb_tag] <= wb_tar_addr;
    end
    if (alloc) begin
      ent_ready[tail] <= 1'b0;
      ent_op[tail]    <= alloc_op;
      ent_rd[tail]    <= alloc_rd;
      ent_func3[tail] <= alloc_func3;
      ent_imm[tail]   <= alloc_imm;
      ent_pc[tail]    <= alloc_pc;
      ent_pred[tail]  <= alloc_pred;
    end
  end

  assign head_tag      = head;
  assign head_op       = ent_op[head];
  assign head_rd       = ent_rd[head];
  assign head_func3    = ent_func3[head];
  assign head_imm      = ent_imm[head];
  assign head_pc       = ent_pc[head];
  assign head_pred     = ent_pred[head];
  assign head_result   = ent_result[head];
  assign head_tar_addr = ent_tar_addr[head];

endmodule

`default_nettype wire

// ==== design/commit_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_unit (
  input  wire                             clk,
  input  wire                             rst,
  input  wire                             head_ready,
  input  wire [rob_pkg::reg_addr_w-1:0]   head_tag,
  input  wire rob_pkg::op_t               head_op,
  input  wire rob_pkg::reg_addr_t         head_rd,
  input  wire [2:0]                       head_func3,
  input  wire rob_pkg::word_t             head_imm,
  input  wire rob_pkg::addr_t             head_pc,
  input  wire                             head_pred,
  input  wire rob_pkg::word_t             head_result,
  input  wire rob_pkg::addr_t             head_tar_addr,
  input  wire                             mem_done,
  output logic                            retire,
  output logic                            mem_store,
  output rob_pkg::addr_t                  mem_addr,
  output rob_pkg::word_t                  mem_data,
  output logic [1:0]                      mem_len,
  output logic                            reg_commit,
  output rob_pkg::reg_addr_t              reg_rd,
  output rob_pkg::word_t                  reg_value,
  output logic [rob_pkg::reg_addr_w-1:0]  reg_tag,
  output logic                            pd_update,
  output logic                            pd_update_taken,
  output logic                            flush,
  output rob_pkg::addr_t                  flush_pc
);
  import rob_pkg::*;

  commit_state_t state;

  logic       taken;
  logic       mispredict;
  logic       writes_reg;
  logic [1:0] store_len;
  addr_t      branch_pc;

  // nothing retires behind a pending store or during a flush
  assign retire = head_ready && (state == commit_idle) && !flush;

  // branch outcome sits in bit 0 of the writeback
  assign taken      = head_result[0];
  assign mispredict = taken != head_pred;
  assign branch_pc  = taken ? head_pc + head_imm : head_pc + instr_len;

  // sb/sh/sw -> 0/1/3
  assign store_len = (head_func3[1:0] == 2'd2) ? 2'd3 : head_func3[1:0];

  // x0 never gets a commit
  assign writes_reg = (head_op inside {op_alu, op_load, op_jal, op_jalr}) && (head_rd != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= commit_idle;
      mem_store  <= 1'b0;
      reg_commit <= 1'b0;
      pd_update  <= 1'b0;
      flush      <= 1'b0;
    end else begin
      mem_store  <= 1'b0;
      reg_commit <= 1'b0;
      pd_update  <= 1'b0;
      flush      <= 1'b0;
      if (state == commit_store_wait && mem_done) begin
        state <= commit_idle;
      end
      if (retire) begin
        case (head_op)
          op_store: begin
            mem_store <= 1'b1;
            state     <= commit_store_wait;
          end
          op_branch: begin
            pd_update <= 1'b1;
            flush     <= mispredict;
          end
          op_jalr: begin
            reg_commit <= writes_reg;
            flush      <= 1'b1;
          end
          default: begin
            reg_commit <= writes_reg;
          end
        endcase
      end
    end
  end

  // payload follows the head on every retire
  always_ff @(posedge clk) begin
    if (retire) begin
      mem_addr        <= head_tar_addr;
      mem_data        <= head_result;
      mem_len         <= store_len;
      reg_rd          <= head_rd;
      reg_value       <= head_result;
      reg_tag         <= head_tag;
      pd_update_taken <= taken;
      flush_pc        <= (head_op == op_jalr) ? head_tar_addr : branch_pc;
    end
  end

endmodule

`default_nettype wire

// ==== design/instr_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_queue #(
  parameter  int iq_depth = 8,
  localparam int tag_w    = $clog2(iq_depth)
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     if_valid,
  input  wire rob_pkg::word_t     if_instr,
  input  wire rob_pkg::addr_t     if_pc,
  input  wire                     dc_valid,
  input  wire rob_pkg::op_t       dc_op,
  input  wire rob_pkg::reg_addr_t dc_rd,
  input  wire [2:0]               dc_func3,
  input  wire rob_pkg::word_t     dc_imm,
  input  wire                     pd_valid,
  input  wire                     pd_taken,
  input  wire                     wb_valid,
  input  wire [tag_w-1:0]         wb_tag,
  input  wire rob_pkg::word_t     wb_result,
  input  wire rob_pkg::addr_t     wb_tar_addr,
  input  wire                     mem_done,
  output wire                     fetch_req,
  output wire                     decode_req,
  output wire rob_pkg::word_t     dec_instr,
  output wire                     pd_req,
  output wire                     pc_write,
  output wire rob_pkg::addr_t     pc_value,
  output wire                     mem_store,
  output wire rob_pkg::addr_t     mem_addr,
  output wire rob_pkg::word_t     mem_data,
  output wire [1:0]               mem_len,
  output wire                     reg_commit,
  output wire rob_pkg::reg_addr_t reg_rd,
  output wire rob_pkg::word_t     reg_value,
  output wire [tag_w-1:0]         reg_tag,
  output wire                     pd_update,
  output wire                     pd_update_taken,
  output wire                     flush,
  output wire rob_pkg::addr_t     flush_pc
);
  import rob_pkg::*;

  // sequencer -> entries
  wire            alloc;
  wire op_t       alloc_op;
  wire reg_addr_t alloc_rd;
  wire [2:0]      alloc_func3;
  wire word_t     alloc_imm;
  wire addr_t     alloc_pc;
  wire            alloc_pred;
  wire            can_alloc;

  // entries -> commit
  wire                  head_ready;
  wire [tag_w-1:0]      head_tag;
  wire op_t             head_op;
  wire reg_addr_t       head_rd;
  wire [2:0]            head_func3;
  wire word_t           head_imm;
  wire addr_t           head_pc;
  wire                  head_pred;
  wire word_t           head_result;
  wire addr_t           head_tar_addr;
  wire                  retire;

  // commit unit carries tags at register-index width
  wire [reg_addr_w-1:0] head_tag_ext;
  wire [reg_addr_w-1:0] reg_tag_ext;

  assign head_tag_ext = reg_addr_w'(head_tag);
  assign reg_tag      = reg_tag_ext[tag_w-1:0];

  fetch_sequencer #(.iq_depth(iq_depth)) fetch_sequencer_inst (.*);

  rob_entries #(.iq_depth(iq_depth)) rob_entries_inst (.*);

  commit_unit commit_unit_inst (
    .head_tag (head_tag_ext),
    .reg_tag  (reg_tag_ext),
    .*
  );

endmodule

`default_nettype wire

// ==== tb/instr_queue_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_queue_asserts #(
  parameter int iq_depth = 8
) (
  input wire clk,
  input wire rst,
  input wire alloc,
  input wire retire,
  input wire fetch_req,
  input wire decode_req,
  input wire pd_req,
  input wire pc_write,
  input wire mem_store,
  input wire reg_commit,
  input wire pd_update,
  input wire flush
);

  int outstanding;

  // live entries, counted from allocations and retires
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(alloc) - int'(retire);
    end
  end

  // control outputs stay quiet while in reset
  a_reset_quiet: assert property (@(posedge clk)
    rst |=> !(fetch_req || decode_req || pd_req || pc_write || mem_store
              || reg_commit || pd_update || flush))
    else $error("control output active during reset");

  // one retire per cycle
  a_one_retire: assert property (@(posedge clk) disable iff (rst)
    $onehot0({reg_commit, mem_store, pd_update}))
    else $error("more than one retire pulse in a cycle");

  // a new fetch must still find a slot for its own entry
  a_fetch_room: assert property (@(posedge clk) disable iff (rst)
    $rose(fetch_req) |-> outstanding < iq_depth - 1)
    else $error("fetch requested with the queue already full");

endmodule

bind instr_queue instr_queue_asserts #(.iq_depth(iq_depth)) asserts_inst (.*);

`default_nettype wire

// ==== tb/instr_queue_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_queue_tb;
  import rob_pkg::*;

  localparam int iq_depth = 8;
  localparam int tag_w    = $clog2(iq_depth);
  localparam int prog_len = 24;

  logic clk;
  logic rst;
  logic if_valid;
  word_t if_instr;
  addr_t if_pc;
  logic dc_valid;
  op_t dc_op;
  reg_addr_t dc_rd;
  logic [2:0] dc_func3;
  word_t dc_imm;
  logic pd_valid;
  logic pd_taken;
  logic wb_valid;
  logic [tag_w-1:0] wb_tag;
  word_t wb_result;
  addr_t wb_tar_addr;
  logic mem_done;
  wire fetch_req, decode_req, pd_req, pc_write, mem_store, reg_commit;
  wire pd_update, pd_update_taken, flush;
  wire word_t dec_instr, mem_data, reg_value;
  wire addr_t pc_value, mem_addr, flush_pc;
  wire [1:0] mem_len;
  wire reg_addr_t reg_rd;
  wire [tag_w-1:0] reg_tag;

  // program table, one row per instruction
  op_t p_op [prog_len];
  reg_addr_t p_rd [prog_len];
  logic [2:0] p_func3 [prog_len];
  word_t p_imm [prog_len];
  addr_t p_pc [prog_len];
  logic p_pred [prog_len];
  word_t p_res [prog_len];
  addr_t p_tar [prog_len];
  int n_instr;

  integer seed;
  int errors;
  int next_idx, cur_idx, req_kind, req_delay, next_tag, store_delay, hold_cnt;
  bit seq_busy, store_busy, wb_hold, done;
  addr_t exp_pc[$];
  int live_idx[$];
  int live_tag[$];
  int wb_idx[$];
  int wb_tag_q[$];

  instr_queue #(.iq_depth(iq_depth)) instr_queue_inst (.*);

  always #50 clk = ~clk;

  task automatic add_instr(op_t op, int rd, int f3, int imm, bit pred, bit outcome, addr_t tar);
    p_op[n_instr]    = op;
    p_rd[n_instr]    = reg_addr_t'(rd);
    p_func3[n_instr] = 3'(f3);
    p_imm[n_instr]   = word_t'(imm);
    p_pc[n_instr]    = 32'h0000_1000 + 32'(n_instr) * 4;
    p_pred[n_instr]  = pred;
    // branches write back only their outcome
    p_res[n_instr]   = (op == op_branch) ? word_t'(outcome)
                                         : 32'h1000_0000 ^ (32'(n_instr) * 32'h0101_0003);
    p_tar[n_instr]   = (op == op_jalr) ? tar : 32'h8000_0000 + 32'(n_instr) * 16;
    n_instr++;
  endtask

  function automatic int rand_delay(int span);
    return 1 + int'($unsigned($random(seed)) % span);
  endfunction

  function automatic word_t instr_word(int i);
    return 32'h0000_0013 + 32'(i) * 32'h100;
  endfunction

  // entries that retire without any output pulse
  function automatic bit is_silent(int i);
    return (p_op[i] inside {op_alu, op_load, op_jal}) && p_rd[i] == 0;
  endfunction

  task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
    assert (exp === act) else begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_retire();
    int i;
    int t;
    bit exp_reg;
    bit exp_fl;
    bit outcome;
    assert (!store_busy) else begin
      $display("retire pulse seen while a store was still waiting for memory");
      errors++;
    end
    while (live_idx.size() > 0 && is_silent(live_idx[0])) begin
      void'(live_idx.pop_front());
      void'(live_tag.pop_front());
    end
    if (live_idx.size() == 0) begin
      $display("retire pulse seen with no entry outstanding");
      errors++;
      return;
    end
    i = live_idx.pop_front();
    t = live_tag.pop_front();
    outcome = p_res[i][0];
    exp_reg = !(p_op[i] inside {op_store, op_branch}) && p_rd[i] != 0;
    exp_fl  = (p_op[i] == op_jalr) || (p_op[i] == op_branch && outcome != p_pred[i]);
    check_val("reg_commit", 32'(exp_reg), 32'(reg_commit));
    check_val("mem_store", 32'(p_op[i] == op_store), 32'(mem_store));
    check_val("pd_update", 32'(p_op[i] == op_branch), 32'(pd_update));
    check_val("flush", 32'(exp_fl), 32'(flush));
    if (exp_reg && reg_commit) begin
      check_val("reg_rd", 32'(p_rd[i]), 32'(reg_rd));
      check_val("reg_value", p_res[i], reg_value);
      check_val("reg_tag", 32'(t), 32'(reg_tag));
    end
    if (p_op[i] == op_store && mem_store) begin
      check_val("store_addr", p_tar[i], mem_addr);
      check_val("store_data", p_res[i], mem_data);
      check_val("store_len", (p_func3[i][1:0] == 2'd2) ? 32'd3 : 32'(p_func3[i][1:0]),
                32'(mem_len));
    end
    if (p_op[i] == op_branch && pd_update) begin
      check_val("pd_update_taken", 32'(outcome), 32'(pd_update_taken));
    end
    if (exp_fl && flush) begin
      if (p_op[i] == op_jalr) begin
        check_val("flush_pc", p_tar[i], flush_pc);
      end else begin
        check_val("flush_pc", outcome ? p_pc[i] + p_imm[i] : p_pc[i] + 4, flush_pc);
      end
    end
  endtask

  always @(posedge clk) begin : env
    int k;
    addr_t e;
    if_valid <= 1'b0;
    dc_valid <= 1'b0;
    pd_valid <= 1'b0;
    wb_valid <= 1'b0;
    mem_done <= 1'b0;
    if (!rst) begin
      // allocation shows up as pc_write
      if (pc_write) begin
        if (exp_pc.size() == 0) begin
          $display("pc_write seen with no instruction in decode");
          errors++;
        end else begin
          e = exp_pc.pop_front();
          check_val("next_pc", e, pc_value);
        end
        if (wb_hold && live_idx.size() >= iq_depth - 1) begin
          $display("instruction allocated while the queue was full");
          errors++;
        end
        live_idx.push_back(cur_idx);
        live_tag.push_back(next_tag);
        wb_idx.push_back(cur_idx);
        wb_tag_q.push_back(next_tag);
        next_tag = (next_tag + 1) % iq_depth;
        seq_busy = 0;
      end
      if (reg_commit || mem_store || pd_update || flush) begin
        check_retire();
      end
      // memory side of a store
      if (mem_done) begin
        store_busy = 0;
      end
      if (mem_store) begin
        store_busy  = 1;
        store_delay = rand_delay(4);
      end else if (store_busy && store_delay > 0) begin
        store_delay--;
        if (store_delay == 0) begin
          mem_done <= 1'b1;
        end
      end
      if (flush) begin
        // queue restarts empty, tags from 0
        exp_pc.delete();
        live_idx.delete();
        live_tag.delete();
        wb_idx.delete();
        wb_tag_q.delete();
        next_tag = 0;
        req_kind = 0;
        seq_busy = 0;
      end else begin
        if (decode_req) begin
          check_val("dec_instr", instr_word(cur_idx), dec_instr);
        end
        if (req_kind == 0) begin
          if (fetch_req && next_idx < n_instr) begin
            req_kind  = 1;
            req_delay = rand_delay(3);
          end else if (decode_req) begin
            req_kind  = 2;
            req_delay = rand_delay(3);
          end else if (pd_req) begin
            req_kind  = 3;
            req_delay = rand_delay(3);
          end
        end else if (req_delay > 1) begin
          req_delay--;
        end else begin
          case (req_kind)
            1: begin
              cur_idx = next_idx;
              next_idx++;
              seq_busy = 1;
              if_valid <= 1'b1;
              if_instr <= instr_word(cur_idx);
              if_pc    <= p_pc[cur_idx];
            end
            2: begin
              dc_valid <= 1'b1;
              dc_op    <= p_op[cur_idx];
              dc_rd    <= p_rd[cur_idx];
              dc_func3 <= p_func3[cur_idx];
              dc_imm   <= p_imm[cur_idx];
              if (p_op[cur_idx] == op_jal) begin
                exp_pc.push_back(p_pc[cur_idx] + p_imm[cur_idx]);
              end else if (p_op[cur_idx] != op_branch) begin
                exp_pc.push_back(p_pc[cur_idx] + 4);
              end
            end
            default: begin
              pd_valid <= 1'b1;
              pd_taken <= p_pred[cur_idx];
              exp_pc.push_back(p_pred[cur_idx] ? p_pc[cur_idx] + p_imm[cur_idx]
                                               : p_pc[cur_idx] + 4);
            end
          endcase
          req_kind = 0;
        end
        // writebacks held back until the queue has filled
        if (wb_hold) begin
          if (live_idx.size() >= iq_depth - 1) begin
            hold_cnt++;
          end
          if (hold_cnt >= 20) begin
            wb_hold = 0;
          end
        end else if (wb_idx.size() > 0 && ($random(seed) & 1)) begin
          k = int'($unsigned($random(seed)) % wb_idx.size());
          wb_valid    <= 1'b1;
          wb_tag      <= tag_w'(wb_tag_q[k]);
          wb_result   <= p_res[wb_idx[k]];
          wb_tar_addr <= p_tar[wb_idx[k]];
          wb_idx.delete(k);
          wb_tag_q.delete(k);
        end
      end
      done = next_idx == n_instr && req_kind == 0 && !seq_busy && live_idx.size() == 0
             && !store_busy && !wb_hold;
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    if_valid = 1'b0;
    if_instr = '0;
    if_pc = '0;
    dc_valid = 1'b0;
    dc_op = op_alu;
    dc_rd = '0;
    dc_func3 = '0;
    dc_imm = '0;
    pd_valid = 1'b0;
    pd_taken = 1'b0;
    wb_valid = 1'b0;
    wb_tag = '0;
    wb_result = '0;
    wb_tar_addr = '0;
    mem_done = 1'b0;
    seed = 32'haee1;
    errors = 0;
    wb_hold = 1;
    n_instr = 0;
    add_instr(op_alu, 1, 0, 0, 0, 0, 0);
    add_instr(op_alu, 2, 0, 0, 0, 0, 0);
    add_instr(op_load, 3, 2, 0, 0, 0, 0);
    add_instr(op_alu, 0, 0, 0, 0, 0, 0);
    add_instr(op_jal, 1, 0, 32'h40, 0, 0, 0);
    add_instr(op_store, 0, 2, 0, 0, 0, 0);
    add_instr(op_alu, 4, 0, 0, 0, 0, 0);
    add_instr(op_branch, 0, 0, 32'h20, 1, 1, 0);
    add_instr(op_store, 0, 0, 0, 0, 0, 0);
    add_instr(op_branch, 0, 1, -8, 0, 0, 0);
    add_instr(op_alu, 5, 0, 0, 0, 0, 0);
    add_instr(op_store, 0, 1, 0, 0, 0, 0);
    // mispredicted not-taken branch
    add_instr(op_branch, 0, 0, 32'h30, 0, 1, 0);
    add_instr(op_alu, 6, 0, 0, 0, 0, 0);
    add_instr(op_alu, 7, 0, 0, 0, 0, 0);
    add_instr(op_jalr, 1, 0, 0, 0, 0, 32'h0000_2000);
    add_instr(op_alu, 8, 0, 0, 0, 0, 0);
    add_instr(op_load, 9, 2, 0, 0, 0, 0);
    add_instr(op_branch, 0, 0, 32'h10, 1, 0, 0);
    add_instr(op_alu, 10, 0, 0, 0, 0, 0);
    add_instr(op_jalr, 0, 0, 0, 0, 0, 32'h0000_3000);
    add_instr(op_alu, 11, 0, 0, 0, 0, 0);
    add_instr(op_store, 0, 2, 0, 0, 0, 0);
    add_instr(op_alu, 12, 0, 0, 0, 0, 0);
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    wait (done);
    repeat (5) @(posedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // watchdog, 60 cycles per instruction
  initial begin
    #(prog_len * 60 * 100);
    $display("timeout: program did not drain from the queue");
    $display("errors: %0d", errors);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
design/rob_pkg.sv
design/fetch_sequencer.sv
design/rob_entries.sv
design/commit_unit.sv
design/instr_queue.sv
tb/instr_queue_asserts.sv
tb/instr_queue_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the queue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module instr_queue_tb -o sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1
